// File: hw/hsid_pkg.sv
`default_nettype none

package hsid_pkg;

    // Sample and word sizes
    localparam int HSID_DATA_WIDTH = 16;          // One band sample
    localparam int HSID_WORD_WIDTH = 32;          // MSE value and accumulator

    // Spectrum geometry
    localparam int HSID_HSP_BANDS         = 16;   // Bands per spectrum
    localparam int HSID_HSP_BANDS_WIDTH   = 4;    // Band index, also the MSE shift
    localparam int HSID_HSP_LIBRARY       = 8;    // References in library
    localparam int HSID_HSP_LIBRARY_WIDTH = 3;    // Reference index

    // Library address is {ref, band}
    localparam int HSID_LIB_ADDR_WIDTH = HSID_HSP_LIBRARY_WIDTH + HSID_HSP_BANDS_WIDTH;

    // One MSE result per reference
    typedef struct packed {
        logic [HSID_WORD_WIDTH-1:0]        value;   // Sum of squares >> band width
        logic [HSID_HSP_LIBRARY_WIDTH-1:0] ref_idx; // Library reference
        logic                              of;      // Sum carried out of 32 bits
    } hsid_mse_t;

    // A kept extreme (min or max)
    typedef struct packed {
        logic [HSID_WORD_WIDTH-1:0]        value;
        logic [HSID_HSP_LIBRARY_WIDTH-1:0] ref_idx;
    } hsid_extreme_t;

    // Values after reset and clear
    localparam hsid_extreme_t HSID_MIN_INIT = '{value: '1, ref_idx: '0}; // Any result beats it
    localparam hsid_extreme_t HSID_MAX_INIT = '{value: '0, ref_idx: '0};

endpackage

`default_nettype wire

// File: hw/hsid_spectrum_mem.sv
`timescale 1ns/1ps
`default_nettype none

module hsid_spectrum_mem
    import hsid_pkg::*;
#(
    parameter int DEPTH = HSID_HSP_BANDS                // Samples held
) (
    input  wire logic                       clk,

    // Host write port
    input  wire logic                       we,         // Write strobe
    input  wire logic [$clog2(DEPTH)-1:0]   waddr,
    input  wire logic [HSID_DATA_WIDTH-1:0] wdata,

    // Controller read port
    input  wire logic                       rd_en,      // Read strobe
    input  wire logic [$clog2(DEPTH)-1:0]   raddr,
    output logic      [HSID_DATA_WIDTH-1:0] rdata       // Valid 1 cycle after rd_en
);

    logic [HSID_DATA_WIDTH-1:0] mem [DEPTH];            // Sample array

    // Write takes effect at the clock edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, holds last data when idle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[raddr];                        // Read-before-write on collision
        end
    end

endmodule

`default_nettype wire

// File: hw/hsid_main_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module hsid_main_ctrl
    import hsid_pkg::*;
(
    input  wire logic                              clk,
    input  wire logic                              rst_n,

    // Host control
    input  wire logic                              start,        // One-cycle pulse
    output logic                                   busy,         // High for the whole run
    output logic                                   done,         // Pulse with busy falling

    // Comparator side
    input  wire logic                              cmp_valid,    // Comparator took a result
    output logic                                   clear,        // Reset kept extremes

    // Memory reads
    output logic                                   rd_en,
    output logic [HSID_HSP_BANDS_WIDTH-1:0]        px_rd_addr,   // Band index
    output logic [HSID_LIB_ADDR_WIDTH-1:0]         lib_rd_addr,  // {ref, band}

    // Markers aligned with memory data
    output logic                                   sample_valid,
    output logic                                   band_first,
    output logic                                   band_last,
    output logic [HSID_HSP_LIBRARY_WIDTH-1:0]      ref_idx
);

    typedef enum logic [1:0] {
        ST_IDLE,                                                 // Waiting for start
        ST_READ,                                                 // One band read per cycle
        ST_DRAIN                                                 // Pipeline emptying
    } state_t;

    localparam logic [HSID_HSP_BANDS_WIDTH-1:0]   LAST_BAND =
        HSID_HSP_BANDS_WIDTH'(HSID_HSP_BANDS - 1);
    localparam logic [HSID_HSP_LIBRARY_WIDTH-1:0] LAST_REF  =
        HSID_HSP_LIBRARY_WIDTH'(HSID_HSP_LIBRARY - 1);

    state_t                              state;
    logic [HSID_HSP_BANDS_WIDTH-1:0]     band_cnt;               // Band being read
    logic [HSID_HSP_LIBRARY_WIDTH-1:0]   ref_cnt;                // Reference being read
    logic [HSID_HSP_LIBRARY_WIDTH-1:0]   res_cnt;                // Results seen by comparator
    logic                                last_read;

    assign busy        = (state != ST_IDLE);
    assign rd_en       = (state == ST_READ);
    assign px_rd_addr  = band_cnt;
    assign lib_rd_addr = {ref_cnt, band_cnt};
    assign last_read   = (ref_cnt == LAST_REF) && (band_cnt == LAST_BAND);

    // Run sequencing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            band_cnt <= '0;
            ref_cnt  <= '0;
            res_cnt  <= '0;
            clear    <= 1'b0;
            done     <= 1'b0;
        end else begin
            clear <= 1'b0;                                       // Pulses by default
            done  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state    <= ST_READ;                     // Busy rises with clear
                        clear    <= 1'b1;
                        band_cnt <= '0;
                        ref_cnt  <= '0;
                        res_cnt  <= '0;
                    end
                end
                ST_READ: begin
                    band_cnt <= band_cnt + 1'b1;                 // Wraps into next ref
                    if (band_cnt == LAST_BAND) begin
                        ref_cnt <= ref_cnt + 1'b1;
                    end
                    if (last_read) begin
                        state <= ST_DRAIN;
                    end
                end
                default: ;                                       // Drain only counts results
            endcase

            // Results already arrive while reading
            if (busy && cmp_valid) begin
                res_cnt <= res_cnt + 1'b1;
                if (res_cnt == LAST_REF) begin
                    state <= ST_IDLE;                            // 8th result taken
                    done  <= 1'b1;
                end
            end
        end
    end

    // Markers follow the read by one cycle like the memory data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_valid <= 1'b0;
            band_first   <= 1'b0;
            band_last    <= 1'b0;
            ref_idx      <= '0;
        end else begin
            sample_valid <= rd_en;
            band_first   <= rd_en && (band_cnt == '0);
            band_last    <= rd_en && (band_cnt == LAST_BAND);
            ref_idx      <= ref_cnt;
        end
    end

endmodule

`default_nettype wire

// File: hw/hsid_sq_acc.sv
`timescale 1ns/1ps
`default_nettype none

module hsid_sq_acc
    import hsid_pkg::*;
(
    input  wire logic                              clk,
    input  wire logic                              rst_n,

    // Samples and markers, aligned by the controller
    input  wire logic                              sample_valid,
    input  wire logic                              band_first,   // Restart the sum
    input  wire logic                              band_last,    // Emit the result
    input  wire logic [HSID_HSP_LIBRARY_WIDTH-1:0] ref_idx,
    input  wire logic [HSID_DATA_WIDTH-1:0]        px_sample,
    input  wire logic [HSID_DATA_WIDTH-1:0]        lib_sample,

    // One result per reference
    output logic                                   mse_valid,
    output hsid_mse_t                              mse
);

    logic [HSID_DATA_WIDTH-1:0]        abs_diff;
    logic [HSID_WORD_WIDTH-1:0]        sq_q;                      // Stage 1 square
    logic                              s1_valid;
    logic                              s1_first;
    logic                              s1_last;
    logic [HSID_HSP_LIBRARY_WIDTH-1:0] s1_ref;
    logic [HSID_WORD_WIDTH-1:0]        acc_q;                     // Running sum
    logic                              of_q;                      // Sticky carry
    logic [HSID_WORD_WIDTH:0]          sum_ext;                   // Sum with carry bit
    logic                              of_next;

    assign abs_diff = (px_sample >= lib_sample) ? px_sample - lib_sample
                                                : lib_sample - px_sample;

    // Stage 1: squared absolute difference
    always_ff @(posedge clk) begin
        sq_q   <= HSID_WORD_WIDTH'(abs_diff) * HSID_WORD_WIDTH'(abs_diff); // Fits in 32 bits
        s1_ref <= ref_idx;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_first <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= sample_valid;
            s1_first <= sample_valid && band_first;
            s1_last  <= sample_valid && band_last;
        end
    end

    // Stage 2: accumulate, first band has no carry in
    assign sum_ext = s1_first ? {1'b0, sq_q} : {1'b0, acc_q} + {1'b0, sq_q};
    assign of_next = sum_ext[HSID_WORD_WIDTH] | (~s1_first & of_q);

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            acc_q <= sum_ext[HSID_WORD_WIDTH-1:0];                 // Wrapped sum
        end
        if (s1_last) begin
            mse.value   <= sum_ext[HSID_WORD_WIDTH-1:0] >> HSID_HSP_BANDS_WIDTH; // Mean
            mse.ref_idx <= s1_ref;
            mse.of      <= of_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            of_q      <= 1'b0;
            mse_valid <= 1'b0;
        end else begin
            if (s1_valid) begin
                of_q <= of_next;
            end
            mse_valid <= s1_last;                                  // 3 cycles after last read
        end
    end

endmodule

`default_nettype wire

// File: hw/hsid_mse_comp.sv
`timescale 1ns/1ps
`default_nettype none

module hsid_mse_comp
    import hsid_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,

    // Result stream in
    input  wire logic      clear,            // Start of a new run
    input  wire logic      mse_in_valid,
    input  wire hsid_mse_t mse_in,

    // Kept extremes
    output logic           mse_out_valid,    // Result taken
    output hsid_extreme_t  min,
    output logic           min_changed,      // One-cycle pulse
    output hsid_extreme_t  max,
    output logic           max_changed       // One-cycle pulse
);

    logic use_in;                                           // Valid and not overflowed
    logic take_min;
    logic take_max;

    assign use_in   = mse_in_valid && !mse_in.of;
    assign take_min = use_in && (mse_in.value <= min.value); // Ties go to later ref
    assign take_max = use_in && (mse_in.value >= max.value);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mse_out_valid <= 1'b0;
            min           <= HSID_MIN_INIT;
            max           <= HSID_MAX_INIT;
            min_changed   <= 1'b0;
            max_changed   <= 1'b0;
        end else if (clear) begin
            mse_out_valid <= 1'b0;                          // Same state as after reset
            min           <= HSID_MIN_INIT;
            max           <= HSID_MAX_INIT;
            min_changed   <= 1'b0;
            max_changed   <= 1'b0;
        end else begin
            mse_out_valid <= mse_in_valid;                  // Overflowed results still count
            min_changed   <= take_min;
            max_changed   <= take_max;
            if (take_min) begin
                min.value   <= mse_in.value;
                min.ref_idx <= mse_in.ref_idx;
            end
            if (take_max) begin
                max.value   <= mse_in.value;
                max.ref_idx <= mse_in.ref_idx;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/hsid_top.sv
`timescale 1ns/1ps
`default_nettype none

module hsid_top
    import hsid_pkg::*;
(
    input  wire logic                            clk,
    input  wire logic                            rst_n,

    // Pixel memory load
    input  wire logic                            px_we,
    input  wire logic [HSID_HSP_BANDS_WIDTH-1:0] px_addr,    // Band index
    input  wire logic [HSID_DATA_WIDTH-1:0]      px_data,

    // Library memory load
    input  wire logic                            lib_we,
    input  wire logic [HSID_LIB_ADDR_WIDTH-1:0]  lib_addr,   // {ref, band}
    input  wire logic [HSID_DATA_WIDTH-1:0]      lib_data,

    // Run control
    input  wire logic                            start,
    output logic                                 busy,
    output logic                                 done,

    // Per-reference results
    output logic                                 mse_valid,
    output hsid_mse_t                            mse,

    // Kept extremes
    output hsid_extreme_t                        min,
    output hsid_extreme_t                        max,
    output logic                                 min_changed,
    output logic                                 max_changed
);

    logic                              clear;
    logic                              cmp_valid;
    logic                              rd_en;
    logic [HSID_HSP_BANDS_WIDTH-1:0]   px_rd_addr;
    logic [HSID_LIB_ADDR_WIDTH-1:0]    lib_rd_addr;
    logic                              sample_valid;
    logic                              band_first;
    logic                              band_last;
    logic [HSID_HSP_LIBRARY_WIDTH-1:0] ref_idx;
    logic [HSID_DATA_WIDTH-1:0]        px_sample;
    logic [HSID_DATA_WIDTH-1:0]        lib_sample;

    hsid_main_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .cmp_valid    (cmp_valid),
        .busy         (busy),
        .done         (done),
        .clear        (clear),
        .rd_en        (rd_en),
        .px_rd_addr   (px_rd_addr),
        .lib_rd_addr  (lib_rd_addr),
        .sample_valid (sample_valid),
        .band_first   (band_first),
        .band_last    (band_last),
        .ref_idx      (ref_idx)
    );

    // One pixel spectrum
    hsid_spectrum_mem #(.DEPTH(HSID_HSP_BANDS)) u_px_mem (
        .clk   (clk),
        .we    (px_we),
        .waddr (px_addr),
        .wdata (px_data),
        .rd_en (rd_en),
        .raddr (px_rd_addr),
        .rdata (px_sample)
    );

    // All reference spectra, ref-major
    hsid_spectrum_mem #(.DEPTH(HSID_HSP_LIBRARY * HSID_HSP_BANDS)) u_lib_mem (
        .clk   (clk),
        .we    (lib_we),
        .waddr (lib_addr),
        .wdata (lib_data),
        .rd_en (rd_en),                                    // Same read as pixel
        .raddr (lib_rd_addr),
        .rdata (lib_sample)
    );

    hsid_sq_acc u_sq_acc (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .band_first   (band_first),
        .band_last    (band_last),
        .ref_idx      (ref_idx),
        .px_sample    (px_sample),
        .lib_sample   (lib_sample),
        .mse_valid    (mse_valid),
        .mse          (mse)
    );

    hsid_mse_comp u_comp (
        .clk           (clk),
        .rst_n         (rst_n),
        .clear         (clear),
        .mse_in_valid  (mse_valid),
        .mse_in        (mse),
        .mse_out_valid (cmp_valid),                        // Counted for done
        .min           (min),
        .min_changed   (min_changed),
        .max           (max),
        .max_changed   (max_changed)
    );

endmodule

`default_nettype wire

// File: tests/hsid_tb.sv
`timescale 1ns/1ps
`default_nettype none

module hsid_tb
    import hsid_pkg::*;
;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int RUN_LATENCY  = 132;                  // Start edge to done
    localparam int RUN_CYCLES   = 128 + RUN_LATENCY + 40; // Load, run, slack
    localparam int NUM_RUNS     = 5;                    // Random test makes two
    localparam longint WATCHDOG_NS = (NUM_RUNS * RUN_CYCLES + RESET_CYCLES + 20) * CLK_PERIOD;

    logic                              clk = 1'b0;
    logic                              rst_n;
    logic                              px_we;
    logic [HSID_HSP_BANDS_WIDTH-1:0]   px_addr;
    logic [HSID_DATA_WIDTH-1:0]        px_data;
    logic                              lib_we;
    logic [HSID_LIB_ADDR_WIDTH-1:0]    lib_addr;
    logic [HSID_DATA_WIDTH-1:0]        lib_data;
    logic                              start;
    logic                              busy;
    logic                              done;
    logic                              mse_valid;
    hsid_mse_t                         mse;
    hsid_extreme_t                     min;
    hsid_extreme_t                     max;
    logic                              min_changed;
    logic                              max_changed;

    logic [HSID_DATA_WIDTH-1:0] px_img  [HSID_HSP_BANDS];                    // Pixel to load
    logic [HSID_DATA_WIDTH-1:0] lib_img [HSID_HSP_LIBRARY * HSID_HSP_BANDS]; // {ref, band}
    hsid_mse_t                  got_res [$];            // Collected results
    bit                         got_min_flag [HSID_HSP_LIBRARY];
    bit                         got_max_flag [HSID_HSP_LIBRARY];
    integer                     seed = 32'hd22a_d4a7;

    hsid_top DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired, the tests did not finish in time");
        $display("FAIL: see errors above");
        $fatal(1);
    end

    task automatic report_failure(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("FAILED at %0t: %s got %0h, expected %0h", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    // Pixel and library written in parallel at one sample per cycle
    task automatic load_memories();
        for (int i = 0; i < HSID_HSP_LIBRARY * HSID_HSP_BANDS; i++) begin
            lib_we   = 1'b1;
            lib_addr = HSID_LIB_ADDR_WIDTH'(i);
            lib_data = lib_img[i];
            px_we    = (i < HSID_HSP_BANDS);
            px_addr  = HSID_HSP_BANDS_WIDTH'(i);
            px_data  = px_img[i % HSID_HSP_BANDS];
            @(posedge clk);
            #2;
        end
        lib_we = 1'b0;
        px_we  = 1'b0;
    endtask

    // Pulse start, gather results and flags until done
    task automatic run_and_collect();
        int cycles;
        bit prev_valid;
        got_res.delete();
        got_min_flag = '{default: 1'b0};
        got_max_flag = '{default: 1'b0};
        cycles     = 0;
        prev_valid = 1'b0;
        start = 1'b1;
        @(posedge clk);                                  // Start edge
        #2;
        start = 1'b0;
        do begin
            @(posedge clk);
            #1;                                          // Outputs settled
            cycles++;
            if (cycles == 1) begin                       // Clear has taken effect
                check_value("min.value after clear", min.value, {HSID_WORD_WIDTH{1'b1}});
                check_value("max.value after clear", max.value, 0);
            end
            if (!done) begin
                check_value("busy during run", busy, 1);
            end
            assert (prev_valid || !(min_changed || max_changed))
                else report_failure("change flag raised without a preceding result");
            if (prev_valid) begin
                got_min_flag[got_res.size() - 1] = min_changed;
                got_max_flag[got_res.size() - 1] = max_changed;
            end
            if (mse_valid) begin
                assert (got_res.size() < HSID_HSP_LIBRARY)
                    else report_failure("more results than library references");
                got_res.push_back(mse);
            end
            prev_valid = mse_valid;
        end while (!done && cycles < RUN_CYCLES);
        #1;
        assert (done) else report_failure("done never arrived after start");
        check_value("done latency", cycles, RUN_LATENCY);
        check_value("busy at done", busy, 0);
        check_value("result count", got_res.size(), HSID_HSP_LIBRARY);
    endtask

    // Exact sum of squared differences for one reference
    function automatic logic [63:0] sum_of_squares(input int r);
        logic [63:0] sum;
        logic [63:0] diff;
        sum = 0;
        for (int b = 0; b < HSID_HSP_BANDS; b++) begin
            diff = (px_img[b] >= lib_img[r * HSID_HSP_BANDS + b])
                 ? px_img[b] - lib_img[r * HSID_HSP_BANDS + b]
                 : lib_img[r * HSID_HSP_BANDS + b] - px_img[b];
            sum += diff * diff;
        end
        return sum;
    endfunction

    // Results, flags and final extremes against the model
    task automatic compare_with_model();
        logic [63:0] sum;
        logic [31:0] exp_val;
        logic        exp_of;
        logic [31:0] mn_val;
        logic [31:0] mx_val;
        int          mn_ref;
        int          mx_ref;
        mn_val = '1;                                    // Init as after clear
        mx_val = '0;
        mn_ref = 0;
        mx_ref = 0;
        for (int i = 0; i < HSID_HSP_LIBRARY; i++) begin
            sum     = sum_of_squares(i);
            exp_of  = (sum[63:32] != 0);                 // Carried out of 32 bits
            exp_val = sum[31:0] >> HSID_HSP_BANDS_WIDTH; // Wrapped sum then mean
            check_value($sformatf("mse[%0d].value", i), got_res[i].value, exp_val);
            check_value($sformatf("mse[%0d].ref_idx", i), got_res[i].ref_idx, i);
            check_value($sformatf("mse[%0d].of", i), got_res[i].of, exp_of);
            check_value($sformatf("min_changed[%0d]", i), got_min_flag[i],
                        !exp_of && exp_val <= mn_val);
            check_value($sformatf("max_changed[%0d]", i), got_max_flag[i],
                        !exp_of && exp_val >= mx_val);
            if (!exp_of && exp_val <= mn_val) begin      // Ties go to the later ref
                mn_val = exp_val;
                mn_ref = i;
            end
            if (!exp_of && exp_val >= mx_val) begin
                mx_val = exp_val;
                mx_ref = i;
            end
        end
        check_value("min.value", min.value, mn_val);
        check_value("min.ref_idx", min.ref_idx, mn_ref);
        check_value("max.value", max.value, mx_val);
        check_value("max.ref_idx", max.ref_idx, mx_ref);
    endtask

    task automatic check_reset_state();
        check_value("busy", busy, 0);
        check_value("done", done, 0);
        check_value("mse_valid", mse_valid, 0);
        check_value("min_changed", min_changed, 0);
        check_value("max_changed", max_changed, 0);
        check_value("min.value", min.value, {HSID_WORD_WIDTH{1'b1}});
        check_value("min.ref_idx", min.ref_idx, 0);
        check_value("max.value", max.value, 0);
        check_value("max.ref_idx", max.ref_idx, 0);
    endtask

    // Ref r is offset by r everywhere so MSE is r squared
    task automatic known_spectra_run();
        px_img = '{default: 16'd100};
        for (int i = 0; i < HSID_HSP_LIBRARY * HSID_HSP_BANDS; i++)
            lib_img[i] = 16'(100 + i / HSID_HSP_BANDS);
        load_memories();
        run_and_collect();
        compare_with_model();
        for (int r = 0; r < HSID_HSP_LIBRARY; r++)
            check_value($sformatf("mse[%0d] square", r), got_res[r].value, r * r);
        check_value("final min", {min.value, min.ref_idx}, {32'd0, 3'd0});
        check_value("final max", {max.value, max.ref_idx}, {32'd49, 3'd7});
    endtask

    // Refs 2 and 5 tie at the minimum
    task automatic change_flag_run();
        int d [HSID_HSP_LIBRARY] = '{5, 3, 1, 4, 6, 1, 2, 7};
        int r;
        px_img = '{default: 16'd200};
        for (int i = 0; i < HSID_HSP_LIBRARY * HSID_HSP_BANDS; i++) begin
            r = i / HSID_HSP_BANDS;
            lib_img[i] = (r % 2 == 0) ? 16'(200 + d[r]) : 16'(200 - d[r]); // Both signs of diff
        end
        load_memories();
        run_and_collect();
        compare_with_model();
        check_value("min_changed on ref 5", got_min_flag[5], 1);
        check_value("min.ref_idx after tie", min.ref_idx, 5);
    endtask

    // Ref 3 overflows and would otherwise be the maximum
    task automatic overflow_run();
        px_img = '{default: 16'd0};
        for (int i = 0; i < HSID_HSP_LIBRARY * HSID_HSP_BANDS; i++)
            lib_img[i] = 16'((i / HSID_HSP_BANDS) * 500);
        for (int b = 0; b < HSID_HSP_BANDS; b++)
            lib_img[3 * HSID_HSP_BANDS + b] = 16'hffff;
        load_memories();
        run_and_collect();
        compare_with_model();
        check_value("mse[3].of", got_res[3].of, 1);
        check_value("min_changed on ref 3", got_min_flag[3], 0);
        check_value("max_changed on ref 3", got_max_flag[3], 0);
        check_value("max.ref_idx", max.ref_idx, 7);
    endtask

    // 12-bit data keeps most sums in range while ref 6 uses full width
    task automatic random_library_runs();
        for (int run = 0; run < 2; run++) begin
            for (int b = 0; b < HSID_HSP_BANDS; b++)
                px_img[b] = 16'($random(seed)) & 16'h0fff;
            for (int i = 0; i < HSID_HSP_LIBRARY * HSID_HSP_BANDS; i++)
                lib_img[i] = (i / HSID_HSP_BANDS == 6) ? 16'($random(seed))
                                                        : 16'($random(seed)) & 16'h0fff;
            load_memories();
            run_and_collect();
            compare_with_model();
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        px_we    = 1'b0;
        px_addr  = '0;
        px_data  = '0;
        lib_we   = 1'b0;
        lib_addr = '0;
        lib_data = '0;
        start    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_reset_state();
        known_spectra_run();
        change_flag_run();
        overflow_run();
        random_library_runs();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: hsid_top.f
hw/hsid_pkg.sv
hw/hsid_spectrum_mem.sv
hw/hsid_main_ctrl.sv
hw/hsid_sq_acc.sv
hw/hsid_mse_comp.sv
hw/hsid_top.sv
tests/hsid_tb.sv
